// ==== lsu_agen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_agen (
    input  wire                clk,
    input  wire                rst,
    input  wire lsu_pkg::lsu_op_t op,
    input  wire                op_valid,
    output logic               op_ready,
    input  wire                abort,
    output lsu_pkg::mem_req_t  ag_req,
    output lsu_pkg::ld_meta_t  ag_meta,
    output logic               ag_valid,
    input  wire                ag_take,
    output logic               unaligned_load,
    output logic               unaligned_store,
    output lsu_pkg::xlen_t     unaligned_epc
);

    lsu_pkg::xlen_t      eff_addr;
    lsu_pkg::xlen_t      store_lanes;
    lsu_pkg::byte_mask_t store_mask;
    logic                misaligned;
    logic                accept;
    logic                load_stage;

    // Base plus sign extended immediate
    assign eff_addr = op.base
        + {{(lsu_pkg::XLEN - lsu_pkg::OFFSET_W){op.offset[lsu_pkg::OFFSET_W-1]}}, op.offset};

    assign op_ready = !ag_valid || ag_take;
    assign accept = op_valid && op_ready;
    assign load_stage = accept && !abort && !misaligned;

    // Natural alignment per access width
    always_comb begin
        case (op.mem_width)
            lsu_pkg::MW_BYTE: misaligned = 1'b0;
            lsu_pkg::MW_HALF: misaligned = eff_addr[0];
            lsu_pkg::MW_WORD: misaligned = |eff_addr[1:0];
            default:          misaligned = |eff_addr[2:0];
        endcase
    end

    // Source is copied into every lane and the mask picks the live one
    always_comb begin
        case (op.mem_width)
            lsu_pkg::MW_BYTE: begin
                store_lanes = {8{op.source[7:0]}};
                store_mask = 8'b0000_0001 << eff_addr[2:0];
            end
            lsu_pkg::MW_HALF: begin
                store_lanes = {4{op.source[15:0]}};
                store_mask = 8'b0000_0011 << {eff_addr[2:1], 1'b0};
            end
            lsu_pkg::MW_WORD: begin
                store_lanes = {2{op.source[31:0]}};
                store_mask = 8'b0000_1111 << {eff_addr[2], 2'b00};
            end
            default: begin
                store_lanes = op.source;
                store_mask = 8'hff;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ag_valid <= 1'b0;
            unaligned_load <= 1'b0;
            unaligned_store <= 1'b0;
        end else begin
            if (load_stage) begin
                ag_valid <= 1'b1;
            end else if (ag_take) begin
                ag_valid <= 1'b0;
            end
            // One cycle pulse whose kind follows wb_en
            unaligned_load <= accept && !abort && misaligned && op.wb_en;
            unaligned_store <= accept && !abort && misaligned && !op.wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load_stage) begin
            ag_req.addr <= eff_addr;
            ag_req.wdata <= store_lanes;
            ag_req.wmask <= store_mask;
            ag_req.wen <= !op.wb_en;
            ag_meta.pc <= op.pc;
            ag_meta.dst <= op.dst;
            ag_meta.wb_en <= op.wb_en;
            ag_meta.byte_off <= eff_addr[2:0];
            ag_meta.mem_unsigned <= op.mem_unsigned;
            ag_meta.mem_width <= op.mem_width;
        end
        if (accept) begin
            unaligned_epc <= op.pc;
        end
    end

    // A faulting operation never reaches the stage register
    a_exc_no_stage: assert property (@(posedge clk) disable iff (rst)
        (unaligned_load || unaligned_store) |-> !ag_valid);

endmodule

`default_nettype wire

// ==== lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  wire lsu_pkg::ld_meta_t resp_meta,
    input  wire lsu_pkg::xlen_t    dm_resp_rdata,
    output lsu_pkg::wb_entry_t     entry
);

    logic [7:0]     lane_b;
    logic [15:0]    lane_h;
    logic [31:0]    lane_w;
    lsu_pkg::xlen_t extended;

    // Lane select from the offset inside the doubleword
    assign lane_b = dm_resp_rdata[{resp_meta.byte_off, 3'b000} +: 8];
    assign lane_h = dm_resp_rdata[{resp_meta.byte_off[2:1], 4'b0000} +: 16];
    assign lane_w = dm_resp_rdata[{resp_meta.byte_off[2], 5'b00000} +: 32];

    always_comb begin
        case (resp_meta.mem_width)
            lsu_pkg::MW_BYTE: begin
                if (resp_meta.mem_unsigned) begin
                    extended = {56'b0, lane_b};
                end else begin
                    extended = {{56{lane_b[7]}}, lane_b};
                end
            end
            lsu_pkg::MW_HALF: begin
                if (resp_meta.mem_unsigned) begin
                    extended = {48'b0, lane_h};
                end else begin
                    extended = {{48{lane_h[15]}}, lane_h};
                end
            end
            lsu_pkg::MW_WORD: begin
                if (resp_meta.mem_unsigned) begin
                    extended = {32'b0, lane_w};
                end else begin
                    extended = {{32{lane_w[31]}}, lane_w};
                end
            end
            default: extended = dm_resp_rdata;
        endcase
    end

    // Stores carry the raw read data
    assign entry.result = resp_meta.wb_en ? extended : dm_resp_rdata;
    assign entry.pc = resp_meta.pc;
    assign entry.dst = resp_meta.dst;
    assign entry.wb_en = resp_meta.wb_en;

endmodule

`default_nettype wire

// ==== lsu_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire lsu_pkg::mem_req_t ag_req,
    input  wire lsu_pkg::ld_meta_t ag_meta,
    input  wire                    ag_valid,
    output logic                   ag_take,
    output lsu_pkg::mem_req_t      dm_req,
    output logic                   dm_req_valid,
    input  wire                    dm_req_ready,
    input  wire                    dm_resp_valid,
    input  wire                    q_space,
    output lsu_pkg::ld_meta_t      resp_meta,
    output logic                   resp_valid,
    output logic                   busy_mem
);

    logic outstanding;

    // Request is held in the agen register until accepted
    assign dm_req = ag_req;

    // One access at a time, and only with room for its result
    assign dm_req_valid = ag_valid && !outstanding && q_space;
    assign ag_take = dm_req_valid && dm_req_ready;

    assign resp_valid = dm_resp_valid && outstanding;
    assign busy_mem = outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (ag_take) begin
            outstanding <= 1'b1;
        end else if (dm_resp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // Metadata of the access in flight
    always_ff @(posedge clk) begin
        if (ag_take) begin
            resp_meta <= ag_meta;
        end
    end

    a_resp_outstanding: assert property (@(posedge clk) disable iff (rst)
        dm_resp_valid |-> outstanding);

    // Memory may stall, the request must not move meanwhile
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (dm_req_valid && !dm_req_ready) |=> (dm_req_valid && $stable(dm_req)));

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int XLEN = 64;
    localparam int OFFSET_W = 12;
    localparam int REG_IDX_W = 5;
    localparam int LANES = XLEN / 8;
    localparam int WB_FIFO_DEPTH = 2;
    localparam int WB_PTR_W = $clog2(WB_FIFO_DEPTH);
    localparam int WB_CNT_W = $clog2(WB_FIFO_DEPTH + 1);

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic signed [OFFSET_W-1:0] offset_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [LANES-1:0] byte_mask_t;
    typedef logic [$clog2(LANES)-1:0] byte_off_t;
    typedef logic [WB_PTR_W-1:0] wb_ptr_t;
    typedef logic [WB_CNT_W-1:0] wb_cnt_t;

    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_e;

    // Issue packet, wb_en is high for loads
    typedef struct packed {
        xlen_t      pc;
        reg_idx_t   dst;
        logic       wb_en;
        xlen_t      base;
        offset_t    offset;
        xlen_t      source;
        logic       mem_unsigned;
        mem_width_e mem_width;
    } lsu_op_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      wdata;
        byte_mask_t wmask;
        logic       wen;
    } mem_req_t;

    // Travels next to the request so the response can be aligned
    typedef struct packed {
        xlen_t      pc;
        reg_idx_t   dst;
        logic       wb_en;
        byte_off_t  byte_off;
        logic       mem_unsigned;
        mem_width_e mem_width;
    } ld_meta_t;

    typedef struct packed {
        xlen_t    result;
        xlen_t    pc;
        reg_idx_t dst;
        logic     wb_en;
    } wb_entry_t;

endpackage

`default_nettype wire

// ==== lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int OPS_PER_TEST = 100;
    localparam int NUM_TESTS = 5;
    localparam int CLK_PERIOD = 40;

    typedef struct packed {
        lsu_pkg::xlen_t epc;
        logic           is_load;
        logic [63:0]    at;
    } exc_exp_t;

    logic               clk;
    logic               rst;
    lsu_pkg::lsu_op_t   op;
    logic               op_valid;
    logic               op_ready;
    logic               abort;
    lsu_pkg::mem_req_t  dm_req;
    logic               dm_req_valid;
    logic               dm_req_ready;
    lsu_pkg::xlen_t     dm_resp_rdata;
    logic               dm_resp_valid;
    lsu_pkg::wb_entry_t wb;
    logic               wb_valid;
    logic               wb_ready;
    logic               busy;
    logic               unaligned_load;
    logic               unaligned_store;
    lsu_pkg::xlen_t     unaligned_epc;

    integer             seed = 32'hb5e21c45;
    int                 errors = 0;
    int                 stall_pct = 0;
    logic [7:0]         model_mem [256];
    logic [7:0]         last_store_addr;
    lsu_pkg::wb_entry_t exp_wb [$];
    exc_exp_t           exp_exc [$];

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

    lsu_tb_mem lsu_tb_mem_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (dm_req),
        .req_valid  (dm_req_valid),
        .req_ready  (dm_req_ready),
        .resp_rdata (dm_resp_rdata),
        .resp_valid (dm_resp_valid)
    );

    lsu_top lsu_top_inst (
        .clk             (clk),
        .rst             (rst),
        .op              (op),
        .op_valid        (op_valid),
        .op_ready        (op_ready),
        .abort           (abort),
        .dm_req          (dm_req),
        .dm_req_valid    (dm_req_valid),
        .dm_req_ready    (dm_req_ready),
        .dm_resp_rdata   (dm_resp_rdata),
        .dm_resp_valid   (dm_resp_valid),
        .wb              (wb),
        .wb_valid        (wb_valid),
        .wb_ready        (wb_ready),
        .busy            (busy),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .unaligned_epc   (unaligned_epc)
    );

    // Little endian read of size bytes from the model
    function automatic lsu_pkg::xlen_t read_model(input logic [7:0] addr, input int size);
        lsu_pkg::xlen_t v;
        v = '0;
        for (int b = 0; b < size; b++) begin
            v[8*b +: 8] = model_mem[8'(addr + b)];
        end
        return v;
    endfunction

    function automatic lsu_pkg::xlen_t extend(input lsu_pkg::xlen_t v, input int size,
                                              input logic uns);
        int sh;
        sh = 64 - 8 * size;
        if (uns) begin
            return (v << sh) >> sh;
        end
        return lsu_pkg::xlen_t'($signed(v << sh) >>> sh);
    endfunction

    task automatic check_wb(input lsu_pkg::wb_entry_t got, input lsu_pkg::wb_entry_t exp);
        if (got.pc !== exp.pc || got.dst !== exp.dst || got.wb_en !== exp.wb_en) begin
            $display("MISMATCH at %0t: pc %h dst %0d wb_en %b, expected pc %h dst %0d wb_en %b",
                     $time, got.pc, got.dst, got.wb_en, exp.pc, exp.dst, exp.wb_en);
            errors++;
        end else if (exp.wb_en && got.result !== exp.result) begin
            $display("MISMATCH at %0t: load pc %h result %h, expected %h",
                     $time, got.pc, got.result, exp.result);
            errors++;
        end
    endtask

    task automatic check_exc(input lsu_pkg::xlen_t epc, input logic is_load, input exc_exp_t exp);
        if (epc !== exp.epc || is_load !== exp.is_load) begin
            $display("MISMATCH at %0t: exception epc %h load %b, expected epc %h load %b",
                     $time, epc, is_load, exp.epc, exp.is_load);
            errors++;
        end else if ($time != exp.at) begin
            $display("ERROR: exception for pc %h came at %0t instead of %0t", epc, $time, exp.at);
            errors++;
        end
    endtask

    // Mode 1 pairs a store with a doubleword load, 2 favours misalignment, 3 aborts
    task automatic build_op(input int mode, input int i, output lsu_pkg::lsu_op_t o,
                            output logic ab);
        int         size;
        logic [7:0] addr;
        logic       odd;
        o.pc = {$random(seed), $random(seed)};
        o.dst = 5'($random(seed));
        o.wb_en = 1'($random(seed));
        o.source = {$random(seed), $random(seed)};
        o.offset = 12'($random(seed));
        o.mem_unsigned = 1'($random(seed));
        o.mem_width = lsu_pkg::mem_width_e'(2'($random(seed)));
        addr = 8'($random(seed));
        ab = 1'b0;
        odd = ({$random(seed)} % 8 == 0);
        case (mode)
            1: begin
                odd = 1'b0;
                o.wb_en = 1'(i % 2);
                if (o.wb_en) begin
                    o.mem_width = lsu_pkg::MW_DOUBLE;
                    addr = last_store_addr;
                end
            end
            2: odd = 1'($random(seed));
            3: ab = 1'($random(seed));
            default: ;
        endcase
        if (odd && o.mem_width == lsu_pkg::MW_BYTE) begin
            o.mem_width = lsu_pkg::MW_HALF;
        end
        size = 1 << o.mem_width;
        addr = addr & ~8'(size - 1);
        if (odd) begin
            addr = addr | 8'(1 + {$random(seed)} % (size - 1));
        end
        if (mode == 1 && !o.wb_en) begin
            last_store_addr = addr;
        end
        o.base = 64'(addr) - {{52{o.offset[11]}}, o.offset};
    endtask

    // Expected results come from the model as it stands at acceptance
    task automatic record_op(input lsu_pkg::lsu_op_t o, input logic ab);
        lsu_pkg::wb_entry_t e;
        exc_exp_t           x;
        logic [7:0]         addr;
        int                 size;
        addr = 8'(o.base + {{52{o.offset[11]}}, o.offset});
        size = 1 << o.mem_width;
        if (ab) begin
            return;
        end
        if ((addr & 8'(size - 1)) != 0) begin
            x.epc = o.pc;
            x.is_load = o.wb_en;
            x.at = $time + CLK_PERIOD;
            exp_exc.push_back(x);
            return;
        end
        e.pc = o.pc;
        e.dst = o.dst;
        e.wb_en = o.wb_en;
        e.result = extend(read_model(addr, size), size, o.mem_unsigned);
        if (!o.wb_en) begin
            for (int b = 0; b < size; b++) begin
                model_mem[8'(addr + b)] = o.source[8*b +: 8];
            end
        end
        exp_wb.push_back(e);
    endtask

    task automatic run_test(input string name, input int mode, input int stall);
        lsu_pkg::lsu_op_t o;
        logic             ab;
        int               errs_before;
        errs_before = errors;
        stall_pct = stall;
        for (int i = 0; i < OPS_PER_TEST; i++) begin
            build_op(mode, i, o, ab);
            #1;
            op = o;
            abort = ab;
            op_valid = 1'b1;
            @(posedge clk);
            while (!op_ready) begin
                @(posedge clk);
            end
            record_op(o, ab);
            if ({$random(seed)} % 4 == 0) begin
                #1;
                op_valid = 1'b0;
                abort = 1'b0;
                @(posedge clk);
            end
        end
        stall_pct = 0;
        #1;
        op_valid = 1'b0;
        abort = 1'b0;
        while (exp_wb.size() != 0 || exp_exc.size() != 0) begin
            // Any result still expected is held somewhere inside the pipeline
            if (exp_wb.size() != 0 && !busy) begin
                $display("ERROR at %0t: busy low while results are still in flight", $time);
                errors++;
            end
            @(negedge clk);
        end
        if (busy) begin
            $display("ERROR at %0t: busy still high after the last entry drained", $time);
            errors++;
        end
        @(posedge clk);
        $display("test %0s: %0d ops, %0d errors", name, OPS_PER_TEST, errors - errs_before);
    endtask

    // Output monitor and writeback ready
    always @(posedge clk) begin
        if (!rst) begin
            if (wb_valid && wb_ready) begin
                if (exp_wb.size() == 0) begin
                    $display("ERROR at %0t: writeback entry with no operation waiting", $time);
                    errors++;
                end else begin
                    check_wb(wb, exp_wb.pop_front());
                end
            end
            if (unaligned_load && unaligned_store) begin
                $display("ERROR at %0t: both exception pulses at once", $time);
                errors++;
            end else if (unaligned_load || unaligned_store) begin
                if (exp_exc.size() == 0) begin
                    $display("ERROR at %0t: exception pulse with no unaligned operation", $time);
                    errors++;
                end else begin
                    check_exc(unaligned_epc, unaligned_load, exp_exc.pop_front());
                end
            end
        end
        #1;
        wb_ready = ({$random(seed)} % 100) >= stall_pct;
    end

    initial begin
        #(NUM_TESTS * OPS_PER_TEST * 40 * CLK_PERIOD);
        $display("Timeout: the run did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        op = '0;
        op_valid = 1'b0;
        abort = 1'b0;
        wb_ready = 1'b0;
        last_store_addr = '0;
        @(negedge rst);
        @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = lsu_tb_mem_inst.mem[i];
        end
        run_test("store_load", 0, 20);
        run_test("store_mask", 1, 20);
        run_test("unaligned", 2, 20);
        run_test("abort", 3, 20);
        run_test("backpressure", 4, 70);
        $display("%0d tests, %0d ops, %0d errors", NUM_TESTS, NUM_TESTS * OPS_PER_TEST, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_tb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_mem (
    input  wire                    clk,
    input  wire                    rst,
    input  wire lsu_pkg::mem_req_t req,
    input  wire                    req_valid,
    output logic                   req_ready,
    output lsu_pkg::xlen_t         resp_rdata,
    output logic                   resp_valid
);

    logic [7:0]     mem [256];
    lsu_pkg::xlen_t held_rdata;
    integer         seed = 32'hb5e21c45;
    int             delay;
    logic           pending;

    // Read the whole doubleword, then apply the masked write
    task automatic serve(input lsu_pkg::mem_req_t r);
        logic [4:0] line;
        line = r.addr[7:3];
        for (int b = 0; b < 8; b++) begin
            held_rdata[8*b +: 8] = mem[{line, 3'(b)}];
            if (r.wen && r.wmask[b]) begin
                mem[{line, 3'(b)}] = r.wdata[8*b +: 8];
            end
        end
        delay = 1 + {$random(seed)} % 4;
        pending = 1'b1;
    endtask

    initial begin
        // Fill depends on every address bit
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 113 + 29);
        end
        req_ready = 1'b0;
        resp_valid = 1'b0;
        resp_rdata = '0;
        pending = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                pending = 1'b0;
            end else if (req_valid && req_ready) begin
                serve(req);
            end
            #1;
            resp_valid = 1'b0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    resp_valid = 1'b1;
                    resp_rdata = held_rdata;
                    pending = 1'b0;
                end
            end
            // No new request while one is in flight
            req_ready = !rst && !pending && ({$random(seed)} % 4 != 0);
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire lsu_pkg::lsu_op_t   op,
    input  wire                     op_valid,
    output logic                    op_ready,
    input  wire                     abort,
    output lsu_pkg::mem_req_t       dm_req,
    output logic                    dm_req_valid,
    input  wire                     dm_req_ready,
    input  wire lsu_pkg::xlen_t     dm_resp_rdata,
    input  wire                     dm_resp_valid,
    output lsu_pkg::wb_entry_t      wb,
    output logic                    wb_valid,
    input  wire                     wb_ready,
    output logic                    busy,
    output logic                    unaligned_load,
    output logic                    unaligned_store,
    output lsu_pkg::xlen_t          unaligned_epc
);

    lsu_pkg::mem_req_t  ag_req;
    lsu_pkg::ld_meta_t  ag_meta;
    logic               ag_valid;
    logic               ag_take;
    lsu_pkg::ld_meta_t  resp_meta;
    logic               resp_valid;
    logic               busy_mem;
    lsu_pkg::wb_entry_t align_entry;
    logic               q_space;
    logic               q_nonempty;

    assign busy = ag_valid || busy_mem || q_nonempty;

    lsu_agen lsu_agen_inst (
        .clk             (clk),
        .rst             (rst),
        .op              (op),
        .op_valid        (op_valid),
        .op_ready        (op_ready),
        .abort           (abort),
        .ag_req          (ag_req),
        .ag_meta         (ag_meta),
        .ag_valid        (ag_valid),
        .ag_take         (ag_take),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .unaligned_epc   (unaligned_epc)
    );

    lsu_mem_stage lsu_mem_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .ag_req        (ag_req),
        .ag_meta       (ag_meta),
        .ag_valid      (ag_valid),
        .ag_take       (ag_take),
        .dm_req        (dm_req),
        .dm_req_valid  (dm_req_valid),
        .dm_req_ready  (dm_req_ready),
        .dm_resp_valid (dm_resp_valid),
        .q_space       (q_space),
        .resp_meta     (resp_meta),
        .resp_valid    (resp_valid),
        .busy_mem      (busy_mem)
    );

    lsu_load_align lsu_load_align_inst (
        .resp_meta     (resp_meta),
        .dm_resp_rdata (dm_resp_rdata),
        .entry         (align_entry)
    );

    // Slot is reserved when the memory accepts the request
    lsu_wb_fifo lsu_wb_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .in_entry   (align_entry),
        .in_valid   (resp_valid),
        .in_reserve (ag_take),
        .q_space    (q_space),
        .wb         (wb),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .q_nonempty (q_nonempty)
    );

endmodule

`default_nettype wire

// ==== lsu_wb_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_wb_fifo (
    input  wire                     clk,
    input  wire                     rst,
    input  wire lsu_pkg::wb_entry_t in_entry,
    input  wire                     in_valid,
    input  wire                     in_reserve,
    output logic                    q_space,
    output lsu_pkg::wb_entry_t      wb,
    output logic                    wb_valid,
    input  wire                     wb_ready,
    output logic                    q_nonempty
);

    lsu_pkg::wb_entry_t slots [lsu_pkg::WB_FIFO_DEPTH];
    lsu_pkg::wb_ptr_t   wr_ptr;
    lsu_pkg::wb_ptr_t   rd_ptr;
    lsu_pkg::wb_cnt_t   count;
    lsu_pkg::wb_cnt_t   occupancy;
    logic               reserved;
    logic               pop;

    assign pop = wb_valid && wb_ready;

    // Held entries plus the one access still in memory
    assign occupancy = count + lsu_pkg::wb_cnt_t'(reserved);
    assign q_space = occupancy < lsu_pkg::wb_cnt_t'(lsu_pkg::WB_FIFO_DEPTH);

    // Head falls through
    assign wb = slots[rd_ptr];
    assign wb_valid = count != '0;
    assign q_nonempty = wb_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            reserved <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (in_reserve) begin
                reserved <= 1'b1;
            end else if (in_valid) begin
                reserved <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slots[wr_ptr] <= in_entry;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (count < lsu_pkg::wb_cnt_t'(lsu_pkg::WB_FIFO_DEPTH)));

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset leaves just after an edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
lsu_pkg.sv
lsu_agen.sv
lsu_mem_stage.sv
lsu_load_align.sv
lsu_wb_fifo.sv
lsu_top.sv
tb_clock_gen.sv
lsu_tb_mem.sv
lsu_tb.sv
